// File: rtl/obi_pkg.sv
/*
  Bus-side definitions for the OBI data port
  - address, data and byte-enable widths
  - memory-type encoding and its bufferable bit
*/

`default_nettype none

package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int OBI_ADDR_W    = 32;
  localparam int OBI_DATA_W    = 32;
  localparam int OBI_BE_W      = OBI_DATA_W / 8;
  localparam int OBI_MEMTYPE_W = 2;

  // Byte address, word aligned when driven on the bus
  typedef logic [OBI_ADDR_W-1:0]    obi_addr_t;
  typedef logic [OBI_DATA_W-1:0]    obi_data_t;
  typedef logic [OBI_BE_W-1:0]      obi_be_t;
  typedef logic [OBI_MEMTYPE_W-1:0] obi_memtype_t;

  // Memory-type bit 0 marks a bufferable transfer
  localparam int OBI_MEMTYPE_BUF_BIT = 0;

endpackage

`default_nettype wire

// File: rtl/lsu_pkg.sv
/*
  Core-side definitions for the load/store path
  - access size enum
  - byte offset type
  - packed load-info record with its field positions
*/

`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  localparam int LSU_SIZE_W = 2;

  typedef enum logic [LSU_SIZE_W-1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Byte position inside a bus word
  localparam int LSU_OFFSET_W = 2;
  typedef logic [LSU_OFFSET_W-1:0] lsu_offset_t;

  //////////////////////////////////////////////////////////////////////
  // Load info record
  //////////////////////////////////////////////////////////////////////

  // Size sits at the MSB end, then offset, then sign-extend
  localparam int LSU_INFO_SEXT_BIT   = 0;
  localparam int LSU_INFO_OFFSET_LSB = LSU_INFO_SEXT_BIT + 1;
  localparam int LSU_INFO_SIZE_LSB   = LSU_INFO_OFFSET_LSB + LSU_OFFSET_W;
  localparam int LSU_INFO_W          = LSU_INFO_SIZE_LSB + LSU_SIZE_W;

  // Kept as a plain vector so it can sit in a simple queue array
  typedef logic [LSU_INFO_W-1:0] lsu_info_t;

endpackage

`default_nettype wire

// File: rtl/lsu_request_gen.sv
/*
  Bus request former for core loads and stores
  - word address and byte-enable decode
  - store data replication into byte lanes
  - bufferable region match for stores
  - load-info packing for the aligner
*/

`default_nettype none

module lsu_request_gen #(
  parameter obi_pkg::obi_addr_t BUF_BASE = 32'h0000_1000,
  parameter obi_pkg::obi_addr_t BUF_MASK = 32'hFFFF_F000
) (
  input  obi_pkg::obi_addr_t    lsu_addr_i,
  input  logic                  lsu_we_i,
  input  lsu_pkg::lsu_size_e    lsu_size_i,
  input  logic                  lsu_sext_i,
  input  obi_pkg::obi_data_t    lsu_wdata_i,
  output obi_pkg::obi_addr_t    obi_addr_o,
  output logic                  obi_we_o,
  output obi_pkg::obi_be_t      obi_be_o,
  output obi_pkg::obi_data_t    obi_wdata_o,
  output obi_pkg::obi_memtype_t obi_memtype_o,
  output lsu_pkg::lsu_info_t    info_o
);

  // Low address bits select the lanes
  lsu_pkg::lsu_offset_t offset;
  // Address falls inside the bufferable window
  logic                 in_buf_region;

  assign offset        = lsu_addr_i[lsu_pkg::LSU_OFFSET_W-1:0];
  assign in_buf_region = ((lsu_addr_i & BUF_MASK) == BUF_BASE);

  // Bus always sees the containing word
  assign obi_addr_o = {lsu_addr_i[obi_pkg::OBI_ADDR_W-1:lsu_pkg::LSU_OFFSET_W],
                       {lsu_pkg::LSU_OFFSET_W{1'b0}}};
  assign obi_we_o   = lsu_we_i;

  //////////////////////////////////////////////////////////////////////
  // Byte enables and lane data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    obi_be_o    = 4'b1111;
    obi_wdata_o = lsu_wdata_i;
    case (lsu_size_i)
      lsu_pkg::LSU_BYTE: begin
        // One lane, picked by the full offset
        obi_be_o    = 4'b0001 << offset;
        obi_wdata_o = {4{lsu_wdata_i[7:0]}};
      end
      lsu_pkg::LSU_HALF: begin
        // Two lanes at offset 0 or 2 for aligned halves
        obi_be_o    = 4'b0011 << offset;
        obi_wdata_o = {2{lsu_wdata_i[15:0]}};
      end
      default: begin
        // Full word
        obi_be_o    = 4'b1111;
        obi_wdata_o = lsu_wdata_i;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Memory type
  //////////////////////////////////////////////////////////////////////

  // Only stores may be bufferable since loads need their data back
  always_comb begin
    obi_memtype_o = '0;
    obi_memtype_o[obi_pkg::OBI_MEMTYPE_BUF_BIT] = lsu_we_i && in_buf_region;
  end

  //////////////////////////////////////////////////////////////////////
  // Load info
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    info_o = '0;
    info_o[lsu_pkg::LSU_INFO_SIZE_LSB +: lsu_pkg::LSU_SIZE_W]     = lsu_size_i;
    info_o[lsu_pkg::LSU_INFO_OFFSET_LSB +: lsu_pkg::LSU_OFFSET_W] = offset;
    info_o[lsu_pkg::LSU_INFO_SEXT_BIT]                            = lsu_sext_i;
  end

endmodule

`default_nettype wire

// File: rtl/lsu_response_filter.sv
/*
  Response filter between the LSU and the data bus
  - outstanding-transfer limit of DEPTH
  - core-side and bus-side transfer counters
  - bufferable history shift register
  - early response for bufferable stores, late bus response absorbed
*/

`default_nettype none

module lsu_response_filter #(
  parameter int DEPTH = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic bufferable_i,
  input  logic ready_i,
  input  logic resp_valid_i,
  output logic valid_o,
  output logic ready_o,
  output logic busy_o,
  output logic resp_valid_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t CNT_MAX = cnt_t'(DEPTH);

  // Transfers granted on the bus and not yet answered by the bus
  cnt_t bus_cnt_q;
  cnt_t bus_cnt_next;
  // Transfers accepted from the core and not yet answered to the core
  cnt_t core_cnt_q;
  cnt_t core_cnt_next;

  logic core_accept;
  logic bus_accept;
  logic room;

  // Bit 1 is the newest granted transfer, bit N the Nth oldest
  // Bit 0 stays low so an empty count selects pass-through
  logic [DEPTH:0] buf_hist_q;
  logic [DEPTH:0] buf_hist_next;

  // Oldest transfer seen from each side
  logic bus_oldest_buf;
  logic core_oldest_buf;

  //////////////////////////////////////////////////////////////////////
  // Request gating
  //////////////////////////////////////////////////////////////////////

  // No new grant once DEPTH transfers are in flight
  assign room    = (bus_cnt_q < CNT_MAX);
  assign valid_o = valid_i && room;
  // Ready is qualified with valid so it marks acceptance on both sides
  assign ready_o = ready_i && valid_o;

  assign core_accept = ready_o && valid_i;
  assign bus_accept  = valid_o && ready_i;

  assign busy_o = (bus_cnt_q != '0) || valid_i;

  //////////////////////////////////////////////////////////////////////
  // Bufferable history
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    buf_hist_next = buf_hist_q;
    if (bus_accept) begin
      // Age every entry by one and insert the new one at bit 1
      buf_hist_next    = {buf_hist_q[DEPTH-1:0], 1'b0};
      buf_hist_next[1] = bufferable_i;
    end
  end

  assign bus_oldest_buf  = buf_hist_q[bus_cnt_q];
  assign core_oldest_buf = buf_hist_q[core_cnt_q];

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    core_cnt_next = core_cnt_q;
    case ({core_accept, resp_valid_o})
      2'b10:   core_cnt_next = core_cnt_q + cnt_t'(1);
      2'b01:   core_cnt_next = core_cnt_q - cnt_t'(1);
      default: core_cnt_next = core_cnt_q;
    endcase

    bus_cnt_next = bus_cnt_q;
    case ({bus_accept, resp_valid_i})
      2'b10:   bus_cnt_next = bus_cnt_q + cnt_t'(1);
      2'b01:   bus_cnt_next = bus_cnt_q - cnt_t'(1);
      default: bus_cnt_next = bus_cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_cnt_q  <= '0;
      core_cnt_q <= '0;
      buf_hist_q <= '0;
    end else begin
      bus_cnt_q  <= bus_cnt_next;
      core_cnt_q <= core_cnt_next;
      buf_hist_q <= buf_hist_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////

  // When the oldest bus transfer is bufferable its bus response is dropped
  // and the core is answered whenever its own oldest transfer is bufferable
  // Otherwise the bus response goes straight through
  assign resp_valid_o = bus_oldest_buf ? core_oldest_buf : resp_valid_i;

endmodule

`default_nettype wire

// File: rtl/lsu_load_align.sv
/*
  Load data aligner
  - DEPTH-entry circular queue of per-transfer load info
  - byte and halfword extraction from the response word
  - zero or sign extension as the head entry asks
*/

`default_nettype none

module lsu_load_align #(
  parameter int DEPTH = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push_i,
  input  lsu_pkg::lsu_info_t info_i,
  input  logic               pop_i,
  input  obi_pkg::obi_data_t rdata_i,
  output obi_pkg::obi_data_t rdata_o
);

  // Keep a one-bit pointer for a single-entry queue
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  localparam ptr_t PTR_LAST = ptr_t'(DEPTH - 1);

  lsu_pkg::lsu_info_t   info_mem [DEPTH];
  ptr_t                 wr_ptr_q;
  ptr_t                 rd_ptr_q;

  // Decoded head entry
  lsu_pkg::lsu_info_t   head_info;
  lsu_pkg::lsu_size_e   head_size;
  lsu_pkg::lsu_offset_t head_offset;
  logic                 head_sext;

  obi_pkg::obi_data_t   shifted;

  // Wrap at DEPTH, not at the power of two
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_inc = (ptr == PTR_LAST) ? '0 : ptr + ptr_t'(1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Info queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push_i) begin
      info_mem[wr_ptr_q] <= info_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  assign head_info   = info_mem[rd_ptr_q];
  assign head_size   = lsu_pkg::lsu_size_e'(
                         head_info[lsu_pkg::LSU_INFO_SIZE_LSB +: lsu_pkg::LSU_SIZE_W]);
  assign head_offset = head_info[lsu_pkg::LSU_INFO_OFFSET_LSB +: lsu_pkg::LSU_OFFSET_W];
  assign head_sext   = head_info[lsu_pkg::LSU_INFO_SEXT_BIT];

  //////////////////////////////////////////////////////////////////////
  // Extract and extend
  //////////////////////////////////////////////////////////////////////

  // Addressed lane moves down to bit 0
  assign shifted = rdata_i >> {head_offset, 3'b000};

  always_comb begin
    case (head_size)
      lsu_pkg::LSU_BYTE: begin
        rdata_o = {{24{head_sext & shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::LSU_HALF: begin
        rdata_o = {{16{head_sext & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        rdata_o = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/lsu_bus.sv
/*
  Load/store bus path top level
  - request generator, response filter and load aligner
  - core-side handshake and OBI data port
*/

`default_nettype none

module lsu_bus #(
  parameter int                 DEPTH    = 2,
  parameter obi_pkg::obi_addr_t BUF_BASE = 32'h0000_1000,
  parameter obi_pkg::obi_addr_t BUF_MASK = 32'hFFFF_F000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Core side
  input  logic                  lsu_valid_i,
  input  logic                  lsu_we_i,
  input  lsu_pkg::lsu_size_e    lsu_size_i,
  input  logic                  lsu_sext_i,
  input  obi_pkg::obi_addr_t    lsu_addr_i,
  input  obi_pkg::obi_data_t    lsu_wdata_i,
  output logic                  lsu_ready_o,
  output logic                  lsu_resp_valid_o,
  output obi_pkg::obi_data_t    lsu_rdata_o,
  output logic                  lsu_busy_o,
  // OBI data port
  output logic                  obi_req_o,
  input  logic                  obi_gnt_i,
  output obi_pkg::obi_addr_t    obi_addr_o,
  output logic                  obi_we_o,
  output obi_pkg::obi_be_t      obi_be_o,
  output obi_pkg::obi_data_t    obi_wdata_o,
  output obi_pkg::obi_memtype_t obi_memtype_o,
  input  logic                  obi_rvalid_i,
  input  obi_pkg::obi_data_t    obi_rdata_i
);

  // Size, offset and sign of the access being requested
  lsu_pkg::lsu_info_t load_info;

  lsu_request_gen #(
    .BUF_BASE (BUF_BASE),
    .BUF_MASK (BUF_MASK)
  ) u_request_gen (
    .lsu_addr_i    (lsu_addr_i),
    .lsu_we_i      (lsu_we_i),
    .lsu_size_i    (lsu_size_i),
    .lsu_sext_i    (lsu_sext_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_be_o      (obi_be_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_memtype_o (obi_memtype_o),
    .info_o        (load_info)
  );

  // Ready doubles as the acceptance strobe, so it pushes the info queue
  lsu_response_filter #(
    .DEPTH (DEPTH)
  ) u_response_filter (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (lsu_valid_i),
    .bufferable_i (obi_memtype_o[obi_pkg::OBI_MEMTYPE_BUF_BIT]),
    .ready_i      (obi_gnt_i),
    .resp_valid_i (obi_rvalid_i),
    .valid_o      (obi_req_o),
    .ready_o      (lsu_ready_o),
    .busy_o       (lsu_busy_o),
    .resp_valid_o (lsu_resp_valid_o)
  );

  lsu_load_align #(
    .DEPTH (DEPTH)
  ) u_load_align (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (lsu_ready_o),
    .info_i  (load_info),
    .pop_i   (lsu_resp_valid_o),
    .rdata_i (obi_rdata_i),
    .rdata_o (lsu_rdata_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_lsu_mem_model.sv
/*
  Bus-side memory model for the OBI data port
  - 1 KiB word array with an address-dependent fill
  - random grant stalls
  - in-order responses 1 to max_delay_i cycles after the grant
  - outstanding-transfer count
*/

`default_nettype none

module tb_lsu_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  int                 stall_pct_i,
  input  int                 max_delay_i,
  input  logic               req_i,
  output logic               gnt_o,
  input  obi_pkg::obi_addr_t addr_i,
  input  logic               we_i,
  input  obi_pkg::obi_be_t   be_i,
  input  obi_pkg::obi_data_t wdata_i,
  output logic               rvalid_o,
  output obi_pkg::obi_data_t rdata_o
);

  localparam int WORDS = 256;

  obi_pkg::obi_data_t mem [WORDS];
  // Read data and due cycle of each granted transfer, oldest first
  obi_pkg::obi_data_t pend_data [$];
  int                 pend_due [$];
  int                 cycle;
  int                 seed;
  int                 word_idx;
  int                 delay;
  int                 lane;
  // Transfers granted and not yet answered, as seen by the testbench
  int                 outstanding;
  logic               stall_q;

  initial begin
    seed = 32'hd9da;
    cycle = 0;
    for (word_idx = 0; word_idx < WORDS; word_idx++) begin
      mem[word_idx] = (word_idx * 32'h0101_0101) ^ 32'h5a3c_96e1;
    end
  end

  // Grant unless this cycle is a stall
  assign gnt_o = req_i && !stall_q;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q     <= 1'b0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
      outstanding <= 0;
      pend_data.delete();
      pend_due.delete();
      cycle = 0;
    end else begin
      if (req_i && gnt_o) begin
        word_idx = addr_i[9:2];
        // Stores land on the grant and loads capture their word here too
        if (we_i) begin
          for (lane = 0; lane < 4; lane++) begin
            if (be_i[lane]) mem[word_idx][8*lane +: 8] = wdata_i[8*lane +: 8];
          end
        end
        delay = 1 + int'($unsigned($random(seed)) % max_delay_i);
        pend_data.push_back(mem[word_idx]);
        pend_due.push_back(cycle + delay - 1);
      end
      // One response per cycle, strictly in grant order
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        rvalid_o <= 1'b1;
        rdata_o  <= pend_data.pop_front();
        void'(pend_due.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
      outstanding <= outstanding + int'(req_i && gnt_o) - int'(rvalid_o);
      stall_q     <= ($unsigned($random(seed)) % 100) < stall_pct_i;
      cycle = cycle + 1;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_lsu_bus.sv
/*
  Testbench for the load/store bus path
  - clock, reset and cycle watchdog
  - reference memory and in-order response scoreboard
  - bus monitor for lanes, memory type, request stability and depth
  - directed tests from reset state to a random mix
*/

`default_nettype none

module tb_lsu_bus;

  localparam int                 DEPTH    = 2;
  localparam obi_pkg::obi_addr_t BUF_BASE = 32'h0000_1000;
  localparam obi_pkg::obi_addr_t BUF_MASK = 32'hFFFF_F000;
  // About 260 accesses, under 40 cycles each even with heavy stalls
  localparam int MAX_CYCLES = 20000;

  logic                  clk;
  logic                  rst_n;
  logic                  lsu_valid;
  logic                  lsu_we;
  lsu_pkg::lsu_size_e    lsu_size;
  logic                  lsu_sext;
  obi_pkg::obi_addr_t    lsu_addr;
  obi_pkg::obi_data_t    lsu_wdata;
  logic                  lsu_ready;
  logic                  lsu_resp_valid;
  obi_pkg::obi_data_t    lsu_rdata;
  logic                  lsu_busy;
  logic                  obi_req;
  logic                  obi_gnt;
  obi_pkg::obi_addr_t    obi_addr;
  logic                  obi_we;
  obi_pkg::obi_be_t      obi_be;
  obi_pkg::obi_data_t    obi_wdata;
  obi_pkg::obi_memtype_t obi_memtype;
  logic                  obi_rvalid;
  obi_pkg::obi_data_t    obi_rdata;
  int                    stall_pct;
  int                    max_delay;

  // Scoreboard indexed by acceptance order
  obi_pkg::obi_data_t exp_data [$];
  bit                 is_load [$];
  bit                 is_buf [$];
  int                 accepted;
  int                 issued;
  int                 core_done;
  int                 bus_done;
  obi_pkg::obi_data_t ref_mem [256];
  string              test_name;
  int                 seed;
  int                 cycles;
  // Request waiting for a grant in the previous cycle
  logic               wait_q;
  logic [70:0]        held_req;

  lsu_bus #(
    .DEPTH    (DEPTH),
    .BUF_BASE (BUF_BASE),
    .BUF_MASK (BUF_MASK)
  ) u_dut (
    .clk (clk), .rst_n (rst_n),
    .lsu_valid_i (lsu_valid), .lsu_we_i (lsu_we), .lsu_size_i (lsu_size),
    .lsu_sext_i (lsu_sext), .lsu_addr_i (lsu_addr), .lsu_wdata_i (lsu_wdata),
    .lsu_ready_o (lsu_ready), .lsu_resp_valid_o (lsu_resp_valid),
    .lsu_rdata_o (lsu_rdata), .lsu_busy_o (lsu_busy),
    .obi_req_o (obi_req), .obi_gnt_i (obi_gnt), .obi_addr_o (obi_addr),
    .obi_we_o (obi_we), .obi_be_o (obi_be), .obi_wdata_o (obi_wdata),
    .obi_memtype_o (obi_memtype), .obi_rvalid_i (obi_rvalid), .obi_rdata_i (obi_rdata)
  );

  tb_lsu_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .stall_pct_i (stall_pct), .max_delay_i (max_delay),
    .req_i (obi_req), .gnt_o (obi_gnt), .addr_i (obi_addr), .we_i (obi_we),
    .be_i (obi_be), .wdata_i (obi_wdata), .rvalid_o (obi_rvalid), .rdata_o (obi_rdata)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reporting and access rules
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s %s: expected %h, actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  function automatic int access_bytes(input lsu_pkg::lsu_size_e size);
    case (size)
      lsu_pkg::LSU_BYTE: access_bytes = 1;
      lsu_pkg::LSU_HALF: access_bytes = 2;
      default:           access_bytes = 4;
    endcase
  endfunction

  // One enable per byte covered by the access
  function automatic obi_pkg::obi_be_t lane_enables(input lsu_pkg::lsu_size_e size,
                                                    input int off);
    int b;
    for (b = 0; b < 4; b++) lane_enables[b] = (b >= off) && (b < off + access_bytes(size));
  endfunction

  function automatic obi_pkg::obi_data_t lane_data(input lsu_pkg::lsu_size_e size,
                                                   input obi_pkg::obi_data_t wdata);
    case (size)
      lsu_pkg::LSU_BYTE: lane_data = {4{wdata[7:0]}};
      lsu_pkg::LSU_HALF: lane_data = {2{wdata[15:0]}};
      default:           lane_data = wdata;
    endcase
  endfunction

  // Pick the addressed bytes, then fill the rest with zero or the sign
  function automatic obi_pkg::obi_data_t load_value(input obi_pkg::obi_data_t word,
      input lsu_pkg::lsu_size_e size, input int off, input logic sext);
    int   b;
    int   n;
    logic sign;
    n = access_bytes(size);
    load_value = '0;
    for (b = 0; b < n; b++) load_value[8*b +: 8] = word[8*(off+b) +: 8];
    sign = sext && load_value[8*n-1];
    for (b = n; b < 4; b++) load_value[8*b +: 8] = {8{sign}};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  task automatic track_responses();
    if (obi_rvalid && bus_done >= accepted) abort_run("Bus response with nothing granted");
    if (obi_rvalid && !is_buf[bus_done] && !lsu_resp_valid) begin
      abort_run("Bus response of a load or plain store not passed to the core");
    end
    if (lsu_resp_valid) begin
      if (core_done >= accepted) abort_run("Core response with no access outstanding");
      // Pass-through must line up with its own bus response
      if (!is_buf[core_done] && (!obi_rvalid || bus_done != core_done)) begin
        abort_run("Core response not in the cycle of its bus response");
      end
      if (is_buf[core_done] && bus_done > core_done) begin
        abort_run("Bufferable store answered after its bus response");
      end
      if (is_load[core_done]) check_value("load data", exp_data[core_done], lsu_rdata);
      core_done++;
    end
    if (obi_rvalid) bus_done++;
  endtask

  task automatic track_request();
    int                 idx;
    int                 off;
    int                 b;
    obi_pkg::obi_be_t   be;
    obi_pkg::obi_data_t lanes;
    logic               buf_exp;
    idx = lsu_addr[9:2];
    off = lsu_addr[1:0];
    if (u_mem.outstanding > DEPTH) abort_run("More than DEPTH transfers on the bus");
    check_value("bus request", lsu_valid && (u_mem.outstanding < DEPTH), obi_req);
    check_value("core ready", obi_req && obi_gnt, lsu_ready);
    check_value("busy", lsu_valid || (u_mem.outstanding != 0), lsu_busy);
    if (wait_q && (!obi_req || held_req != {obi_addr, obi_we, obi_be, obi_wdata, obi_memtype})) begin
      abort_run("Bus request changed while waiting for a grant");
    end
    wait_q   = obi_req && !obi_gnt;
    held_req = {obi_addr, obi_we, obi_be, obi_wdata, obi_memtype};
    if (lsu_valid && lsu_ready) begin
      be      = lane_enables(lsu_size, off);
      lanes   = lane_data(lsu_size, lsu_wdata);
      buf_exp = lsu_we && ((lsu_addr & BUF_MASK) == BUF_BASE);
      check_value("bus address", {lsu_addr[31:2], 2'b00}, obi_addr);
      check_value("write enable", lsu_we, obi_we);
      check_value("byte enables", be, obi_be);
      check_value("bufferable bit", buf_exp, obi_memtype[obi_pkg::OBI_MEMTYPE_BUF_BIT]);
      if (lsu_we) begin
        check_value("store lanes", lanes, obi_wdata);
        for (b = 0; b < 4; b++) begin
          if (be[b]) ref_mem[idx][8*b +: 8] = lanes[8*b +: 8];
        end
        exp_data.push_back('0);
      end else begin
        exp_data.push_back(load_value(ref_mem[idx], lsu_size, off, lsu_sext));
      end
      is_load.push_back(!lsu_we);
      is_buf.push_back(buf_exp);
      accepted++;
    end
  endtask

  // Responses go first since they never belong to this cycle's acceptance
  always @(negedge clk) begin
    if (rst_n) begin
      track_responses();
      track_request();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) abort_run("Timeout: the run hit its cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  // Called 1 unit after a rising edge, returns 1 unit after acceptance
  task automatic issue_access(input logic we, input lsu_pkg::lsu_size_e size,
      input logic sext, input obi_pkg::obi_addr_t addr, input obi_pkg::obi_data_t wdata);
    lsu_valid = 1'b1;
    lsu_we    = we;
    lsu_size  = size;
    lsu_sext  = sext;
    lsu_addr  = addr;
    lsu_wdata = wdata;
    issued++;
    @(negedge clk);
    while (!lsu_ready) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic random_access();
    lsu_pkg::lsu_size_e size;
    obi_pkg::obi_addr_t addr;
    size = lsu_pkg::lsu_size_e'($unsigned($random(seed)) % 3);
    addr = ($random(seed) & 32'h0000_03FC) | (($random(seed) & 1) ? BUF_BASE : '0);
    // Aligned offsets only so nothing crosses a word
    if (size == lsu_pkg::LSU_BYTE) addr[1:0] = $random(seed);
    if (size == lsu_pkg::LSU_HALF) addr[1]   = $random(seed);
    issue_access($random(seed), size, $random(seed), addr, $random(seed));
  endtask

  // Wait until the bus is idle, then count the core responses
  task automatic drain_responses();
    lsu_valid = 1'b0;
    @(negedge clk);
    #1;
    while (bus_done != accepted || lsu_busy) begin
      @(negedge clk);
      #1;
    end
    repeat (4) @(negedge clk);
    #1;
    check_value("core responses", issued, core_done);
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    test_name = "reset";
    repeat (10) begin
      @(negedge clk);
      check_value("req in reset", 0, obi_req);
      check_value("resp in reset", 0, lsu_resp_valid);
      check_value("busy in reset", 0, lsu_busy);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value("req idle", 0, obi_req);
      check_value("ready idle", 0, lsu_ready);
      check_value("resp idle", 0, lsu_resp_valid);
      check_value("busy idle", 0, lsu_busy);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic word_store_load();
    test_name = "word_access";
    issue_access(1'b1, lsu_pkg::LSU_WORD, 1'b0, 32'h0000_0100, 32'hcafe_f00d);
    issue_access(1'b0, lsu_pkg::LSU_WORD, 1'b0, 32'h0000_0100, '0);
    drain_responses();
  endtask

  task automatic sub_word_lanes();
    int off;
    test_name = "sub_word";
    for (off = 0; off < 4; off++) begin
      issue_access(1'b1, lsu_pkg::LSU_BYTE, 1'b0, 32'h200 + off, 32'h5a5a_5a80 + 32'h13 * off);
      issue_access(1'b0, lsu_pkg::LSU_BYTE, 1'b0, 32'h200 + off, '0);
      issue_access(1'b0, lsu_pkg::LSU_BYTE, 1'b1, 32'h200 + off, '0);
      // Untouched word that still holds fill data
      issue_access(1'b0, lsu_pkg::LSU_BYTE, 1'b1, 32'h2f0 + off, '0);
    end
    for (off = 0; off < 4; off += 2) begin
      issue_access(1'b1, lsu_pkg::LSU_HALF, 1'b0, 32'h240 + off, 32'h1234_8765 + off);
      issue_access(1'b0, lsu_pkg::LSU_HALF, 1'b0, 32'h240 + off, '0);
      issue_access(1'b0, lsu_pkg::LSU_HALF, 1'b1, 32'h240 + off, '0);
    end
    drain_responses();
  endtask

  task automatic bufferable_stores();
    int k;
    test_name = "bufferable";
    max_delay = 8;
    for (k = 0; k < 6; k++) begin
      issue_access(1'b1, lsu_pkg::LSU_WORD, 1'b0, 32'h1040 + 4 * (k % 2), 32'h8000_0000 + k);
    end
    issue_access(1'b0, lsu_pkg::LSU_WORD, 1'b0, 32'h1040, '0);
    // Same word through its alias outside the region
    issue_access(1'b0, lsu_pkg::LSU_WORD, 1'b0, 32'h0044, '0);
    drain_responses();
  endtask

  task automatic back_pressure();
    test_name = "back_pressure";
    stall_pct = 60;
    max_delay = 8;
    repeat (30) random_access();
    drain_responses();
  endtask

  task automatic random_mix();
    test_name = "random_mix";
    stall_pct = 25;
    max_delay = 4;
    repeat (200) random_access();
    drain_responses();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    lsu_valid = 1'b0;
    lsu_we    = 1'b0;
    lsu_size  = lsu_pkg::LSU_WORD;
    lsu_sext  = 1'b0;
    lsu_addr  = '0;
    lsu_wdata = '0;
    stall_pct = 0;
    max_delay = 3;
    seed      = 32'hd9da;
    accepted  = 0;
    issued    = 0;
    core_done = 0;
    bus_done  = 0;
    cycles    = 0;
    wait_q    = 1'b0;
    held_req  = '0;
    // Same address-dependent fill as the memory model
    for (int i = 0; i < 256; i++) ref_mem[i] = (i * 32'h0101_0101) ^ 32'h5a3c_96e1;
    reset_state();
    word_store_load();
    sub_word_lanes();
    bufferable_stores();
    back_pressure();
    random_mix();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_bus.f
rtl/obi_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_request_gen.sv
rtl/lsu_response_filter.sv
rtl/lsu_load_align.sv
rtl/lsu_bus.sv
verification/tb_lsu_mem_model.sv
verification/tb_lsu_bus.sv
